// File: csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// countdown timer width
`define CSR_TIMER_W 32

// register number width
`define CSR_NUM_W 14

// ecfg local interrupt enable field
`define CSR_LIE_W 13

// direct address mode, plv0, interrupts off
`define CSR_CRMD_RST 9'h008

`endif

// File: csr_pkg.sv
`include "csr_settings.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        NONE    = 3'd0,
        CSRRD   = 3'd1,
        CSRWR   = 3'd2,
        CSRXCHG = 3'd3,
        ERTN    = 3'd4,
        EXCP    = 3'd5,
        INTE    = 3'd6  // raised by decode only
    } csr_op_e;

    typedef enum logic [`CSR_NUM_W-1:0] {
        CSR_CRMD   = `CSR_NUM_W'('h00),
        CSR_PRMD   = `CSR_NUM_W'('h01),
        CSR_ECFG   = `CSR_NUM_W'('h04),
        CSR_ESTAT  = `CSR_NUM_W'('h05),
        CSR_ERA    = `CSR_NUM_W'('h06),
        CSR_BADV   = `CSR_NUM_W'('h07),
        CSR_EENTRY = `CSR_NUM_W'('h0c),
        CSR_SAVE0  = `CSR_NUM_W'('h30),
        CSR_SAVE1  = `CSR_NUM_W'('h31),
        CSR_SAVE2  = `CSR_NUM_W'('h32),
        CSR_SAVE3  = `CSR_NUM_W'('h33),
        CSR_TID    = `CSR_NUM_W'('h40),
        CSR_TCFG   = `CSR_NUM_W'('h41),
        CSR_TVAL   = `CSR_NUM_W'('h42),
        CSR_TICLR  = `CSR_NUM_W'('h44)
    } csr_addr_e;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        csr_addr_e   num;
        logic [31:0] wdata;
        logic [31:0] wmask;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_req_t;

    typedef struct packed {
        csr_op_e     op;
        csr_addr_e   num;
        logic [31:0] wdata;  // already merged through the mask
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_cmd_t;

    typedef struct packed {
        logic        flush;
        logic [31:0] pc;
        logic [31:0] rdata;
    } csr_resp_t;

    typedef struct packed {
        logic [8:0]             crmd;
        logic [2:0]             prmd;
        logic [`CSR_LIE_W-1:0]  ecfg_lie;
        logic [1:0]             estat_is;
        logic [5:0]             estat_ecode;
        logic [8:0]             estat_esubcode;
        logic [31:0]            era;
        logic [31:0]            badv;
        logic [31:0]            eentry;
        logic [3:0][31:0]       save;
        logic [31:0]            tid;
        logic [`CSR_TIMER_W-1:0] tcfg;
    } csr_state_t;

    typedef struct packed {
        logic [`CSR_TIMER_W-1:0] tval;
        logic                    ti;
    } tmr_status_t;

    typedef struct packed {
        logic [`CSR_TIMER_W-1:0] tcfg;
        logic                    wr;
        logic                    clr;
    } tmr_ctrl_t;

endpackage

// File: csr_decode.sv
`include "csr_settings.svh"

module csr_decode (
    input  csr_pkg::csr_req_t    req,
    input  csr_pkg::csr_state_t  state,
    input  csr_pkg::tmr_status_t tmr,
    input  logic [7:0]           hw_int,
    output csr_pkg::csr_cmd_t    cmd,
    output csr_pkg::csr_resp_t   resp,
    output logic                 cmd_valid
);
    import csr_pkg::*;

    logic [`CSR_LIE_W-1:0] int_vec;
    logic                  inte;
    csr_op_e               op;
    logic [31:0]           estat;
    logic [31:0]           rdata;
    logic [31:0]           mask;

    // ipi at bit 12 and bit 10 are not wired
    assign int_vec = {1'b0, tmr.ti, 1'b0, hw_int, state.estat_is};

    assign inte = req.valid && state.crmd[2] && (|(int_vec & state.ecfg_lie));

    // interrupt wins over whatever the slot carries
    assign op = inte ? INTE : req.op;

    assign cmd_valid = req.valid && (op != NONE);

    assign estat = {1'b0, state.estat_esubcode, state.estat_ecode, 3'b0, int_vec};

    always_comb
    begin
        case (req.num)
            CSR_CRMD:   rdata = {23'b0, state.crmd};
            CSR_PRMD:   rdata = {29'b0, state.prmd};
            CSR_ECFG:   rdata = 32'(state.ecfg_lie);
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = state.era;
            CSR_BADV:   rdata = state.badv;
            CSR_EENTRY: rdata = state.eentry;
            CSR_SAVE0,
            CSR_SAVE1,
            CSR_SAVE2,
            CSR_SAVE3:  rdata = state.save[req.num[1:0]];
            CSR_TID:    rdata = state.tid;
            CSR_TCFG:   rdata = 32'(state.tcfg);
            CSR_TVAL:   rdata = 32'(tmr.tval);
            default:    rdata = '0;  // ticlr reads as zero
        endcase
    end

    assign mask = (op == CSRXCHG) ? req.wmask : '1;

    always_comb
    begin
        cmd.op    = op;
        cmd.num   = req.num;
        cmd.wdata = (rdata & ~mask) | (req.wdata & mask);
        cmd.pc    = req.pc;
        cmd.badv  = req.badv;
        if (inte)
        begin
            cmd.ecode    = 6'd0;  // int
            cmd.esubcode = 9'd0;
        end
        else
        begin
            cmd.ecode    = req.ecode;
            cmd.esubcode = req.esubcode;
        end
    end

    always_comb
    begin
        resp.rdata = rdata;
        resp.flush = req.valid && (op != NONE) && (op != CSRRD);
        case (op)
            ERTN:       resp.pc = state.era;
            EXCP, INTE: resp.pc = state.eentry;
            default:    resp.pc = req.pc + 32'd4;
        endcase
    end

endmodule

// File: csr_stage_reg.sv
module csr_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t d,
    output logic     valid_out,
    output payload_t q
);

    always_ff @(posedge clk)
    begin
        if (!rstn || (flush && !stall))
        begin
            valid_out <= 1'b0;
            q         <= '0;  // response flush must drop with it
        end
        else if (!stall)
        begin
            valid_out <= valid_in;
            q         <= d;
        end
    end

endmodule

// File: csr_commit.sv
`include "csr_settings.svh"

module csr_commit (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 cmd_valid,
    input  csr_pkg::csr_cmd_t    cmd,
    input  csr_pkg::tmr_status_t tmr,
    output csr_pkg::csr_state_t  state,
    output csr_pkg::tmr_ctrl_t   tctl,
    output logic                 excp_flush,
    output logic                 ertn_flush
);
    import csr_pkg::*;

    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [5:0] ECODE_ALE = 6'h09;
    localparam logic [`CSR_LIE_W-1:0] LIE_WMASK = 13'h1bff;  // bit 10 reserved

    logic commit_en;
    logic wr_en;
    logic tcfg_wr;

    assign commit_en = cmd_valid && !stall;
    assign wr_en     = commit_en && (cmd.op == CSRWR || cmd.op == CSRXCHG);
    assign tcfg_wr   = wr_en && (cmd.num == CSR_TCFG);

    // timer sees the new config at the same edge the register takes it
    always_comb
    begin
        tctl.wr   = tcfg_wr;
        tctl.tcfg = tcfg_wr ? cmd.wdata[`CSR_TIMER_W-1:0] : state.tcfg;
        tctl.clr  = wr_en && (cmd.num == CSR_TICLR) && cmd.wdata[0] && tmr.ti;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state      <= '0;
            state.crmd <= `CSR_CRMD_RST;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (commit_en)
            begin
                case (cmd.op)
                    EXCP, INTE:
                    begin
                        state.prmd           <= state.crmd[2:0];  // plv and ie
                        state.crmd[2:0]      <= 3'b0;
                        state.era            <= cmd.pc;
                        state.estat_ecode    <= cmd.ecode;
                        state.estat_esubcode <= cmd.esubcode;
                        if (cmd.ecode == ECODE_ADE || cmd.ecode == ECODE_ALE)
                            state.badv <= cmd.badv;
                        excp_flush <= 1'b1;
                    end
                    ERTN:
                    begin
                        state.crmd[2:0] <= state.prmd;
                        ertn_flush      <= 1'b1;
                    end
                    CSRWR, CSRXCHG:
                    begin
                        case (cmd.num)
                            CSR_CRMD:
                            begin
                                state.crmd[2:0] <= cmd.wdata[2:0];
                                state.crmd[8:5] <= cmd.wdata[8:5];
                                // da and pg must stay exclusive
                                if (cmd.wdata[4] ^ cmd.wdata[3])
                                    state.crmd[4:3] <= cmd.wdata[4:3];
                            end
                            CSR_PRMD:   state.prmd     <= cmd.wdata[2:0];
                            CSR_ECFG:   state.ecfg_lie <= cmd.wdata[`CSR_LIE_W-1:0] & LIE_WMASK;
                            CSR_ESTAT:  state.estat_is <= cmd.wdata[1:0];  // sw bits only
                            CSR_ERA:    state.era      <= cmd.wdata;
                            CSR_BADV:   state.badv     <= cmd.wdata;
                            CSR_EENTRY: state.eentry   <= {cmd.wdata[31:6], 6'b0};
                            CSR_SAVE0,
                            CSR_SAVE1,
                            CSR_SAVE2,
                            CSR_SAVE3:  state.save[cmd.num[1:0]] <= cmd.wdata;
                            CSR_TID:    state.tid      <= cmd.wdata;
                            CSR_TCFG:   state.tcfg     <= cmd.wdata[`CSR_TIMER_W-1:0];
                            default:    ;  // tval read only, ticlr goes to the timer
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: csr_timer.sv
`include "csr_settings.svh"

module csr_timer (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::tmr_ctrl_t   tctl,
    output csr_pkg::tmr_status_t tmr
);

    logic                    en;
    logic                    periodic;
    logic                    at_zero;
    logic [`CSR_TIMER_W-1:0] init_val;

    assign en       = tctl.tcfg[0];
    assign periodic = tctl.tcfg[1];
    assign at_zero  = (tmr.tval == '0);
    assign init_val = {tctl.tcfg[`CSR_TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tmr <= '0;
        end
        else
        begin
            // clear beats a new expiry in the same cycle
            if (tctl.clr)
                tmr.ti <= 1'b0;
            else if (en && !tctl.wr && at_zero)
                tmr.ti <= 1'b1;

            if (tctl.wr && en)
                tmr.tval <= init_val;
            else if (en && at_zero && periodic)
                tmr.tval <= init_val;
            else if (en && tmr.tval != '1)
                tmr.tval <= tmr.tval - 1'b1;  // one shot parks at all ones
        end
    end

endmodule

// File: csr_unit.sv
module csr_unit (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush,
    input  csr_pkg::csr_req_t  req,
    input  logic [7:0]         hw_int,
    output csr_pkg::csr_resp_t resp,
    output logic               excp_flush,
    output logic               ertn_flush,
    output logic [8:0]         crmd
);
    import csr_pkg::*;

    csr_cmd_t    cmd_d;
    csr_cmd_t    cmd_q;
    csr_resp_t   resp_d;
    logic        cmd_valid_d;
    logic        cmd_valid_q;
    csr_state_t  state;
    tmr_status_t tmr;
    tmr_ctrl_t   tctl;

    assign crmd = state.crmd;

    csr_decode u_decode (
        .req       (req),
        .state     (state),
        .tmr       (tmr),
        .hw_int    (hw_int),
        .cmd       (cmd_d),
        .resp      (resp_d),
        .cmd_valid (cmd_valid_d)
    );

    csr_stage_reg #(.payload_t(csr_cmd_t)) u_cmd_reg (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .flush     (flush),
        .valid_in  (cmd_valid_d),
        .d         (cmd_d),
        .valid_out (cmd_valid_q),
        .q         (cmd_q)
    );

    // response validity rides in resp.flush
    csr_stage_reg #(.payload_t(csr_resp_t)) u_resp_reg (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .flush     (flush),
        .valid_in  (req.valid),
        .d         (resp_d),
        .valid_out (),
        .q         (resp)
    );

    csr_commit u_commit (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .cmd_valid  (cmd_valid_q),
        .cmd        (cmd_q),
        .tmr        (tmr),
        .state      (state),
        .tctl       (tctl),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_timer u_timer (
        .clk  (clk),
        .rstn (rstn),
        .tctl (tctl),
        .tmr  (tmr)
    );

endmodule

// File: csr_props.sv
`include "csr_settings.svh"

module csr_props (
    input logic               clk,
    input logic               rstn,
    input logic               stall,
    input logic               flush,
    input csr_pkg::csr_req_t  req,
    input csr_pkg::csr_resp_t resp_d,
    input csr_pkg::csr_resp_t resp,
    input logic               excp_flush,
    input logic               ertn_flush,
    input logic [8:0]         crmd
);

    int unsigned fail_count = 0;  // failed properties so far

    // accepted request is answered on the next edge
    resp_follows_accept: assert property (@(posedge clk) disable iff (!rstn)
        req.valid && !stall && !flush |=> resp == $past(resp_d))
        else
        begin
            $error("resp does not match the accepted request");
            fail_count++;
        end

    resp_held_under_stall: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(resp))
        else
        begin
            $error("resp changed while stalled");
            fail_count++;
        end

    resp_dropped_on_flush: assert property (@(posedge clk) disable iff (!rstn)
        flush && !stall |=> !resp.flush)
        else
        begin
            $error("flushed request still flushes");
            fail_count++;
        end

    excp_flush_single: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else
        begin
            $error("excp_flush longer than one cycle");
            fail_count++;
        end

    ertn_flush_single: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else
        begin
            $error("ertn_flush longer than one cycle");
            fail_count++;
        end

    // no disable here, this one watches reset itself
    idle_after_reset: assert property (@(posedge clk)
        !rstn |=> !resp.flush && !excp_flush && !ertn_flush && crmd == `CSR_CRMD_RST)
        else
        begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind csr_unit csr_props u_props (
    .clk        (clk),
    .rstn       (rstn),
    .stall      (stall),
    .flush      (flush),
    .req        (req),
    .resp_d     (resp_d),
    .resp       (resp),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush),
    .crmd       (crmd)
);

// File: tb_clock.sv
module tb_clock #(
    parameter int period     = 20,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial
    begin
        rstn = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #2 rstn = 1'b1;  // released off the edge
    end

endmodule

// File: csr_tb.sv
`include "csr_settings.svh"

module csr_tb;
    import csr_pkg::*;

    localparam logic [5:0] ecode_sys = 6'h0b;
    localparam int         max_wait  = 200;

    logic       clk;
    logic       rstn;
    logic       stall;
    logic       flush;
    csr_req_t   req;
    logic [7:0] hw_int;
    csr_resp_t  resp;
    logic       excp_flush;
    logic       ertn_flush;
    logic [8:0] crmd;

    tb_clock #(.period(20), .rst_cycles(5)) u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_unit DUT (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .hw_int     (hw_int),
        .resp       (resp),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
    endtask

    // one request, accepted at the second edge; resp sampled after it
    task automatic issue(input csr_op_e op, input csr_addr_e num, input logic [31:0] wdata,
                         input logic [31:0] wmask, input logic [31:0] pc,
                         input logic [5:0] ecode, output csr_resp_t r);
        @(posedge clk);
        #2;
        req.valid    = 1'b1;
        req.op       = op;
        req.num      = num;
        req.wdata    = wdata;
        req.wmask    = wmask;
        req.pc       = pc;
        req.ecode    = ecode;
        req.esubcode = '0;
        req.badv     = '0;
        @(posedge clk);
        #2;
        req = '0;
        r   = resp;
    endtask

    task automatic read_reg(input csr_addr_e num, output logic [31:0] val);
        csr_resp_t r;
        issue(CSRRD, num, '0, '0, 32'h1c00_0000, '0, r);
        val = r.rdata;
    endtask

    task automatic write_reg(input csr_addr_e num, input logic [31:0] val);
        csr_resp_t r;
        issue(CSRWR, num, val, '0, 32'h1c00_0100, '0, r);
        expect_eq("csrwr flush", 32'(r.flush), 32'd1);
    endtask

    task automatic wait_pulse(input bit ertn);
        int n;
        n = 0;
        while (!(ertn ? ertn_flush : excp_flush) && n < max_wait)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!(ertn ? ertn_flush : excp_flush))
            abort_run(ertn ? "ertn_flush never pulsed" : "excp_flush never pulsed");
    endtask

    initial
    begin
        logic [31:0] v_old;
        logic [31:0] v_new;
        logic [31:0] mask;
        logic [31:0] got;
        logic [31:0] eentry;
        logic [31:0] epc;
        csr_resp_t   r;
        csr_resp_t   held;
        int          i;
        bit          taken;

        stall  = 1'b0;
        flush  = 1'b0;
        req    = '0;
        hw_int = '0;
        void'($urandom(32'hd0a8));

        i = 0;
        while (rstn !== 1'b1 && i < max_wait)
        begin
            @(posedge clk);
            i++;
        end
        if (rstn !== 1'b1)
            abort_run("reset was never released");
        #2;
        expect_eq("crmd after reset", 32'(crmd), 32'(`CSR_CRMD_RST));
        expect_eq("resp.flush after reset", 32'(resp.flush), 32'd0);
        expect_eq("excp_flush after reset", 32'(excp_flush), 32'd0);
        expect_eq("ertn_flush after reset", 32'(ertn_flush), 32'd0);

        v_old = $urandom;
        issue(CSRWR, CSR_SAVE0, v_old, '0, 32'h1c00_0010, '0, r);
        expect_eq("csrwr next pc", r.pc, 32'h1c00_0014);
        read_reg(CSR_SAVE0, got);
        expect_eq("save0 readback", got, v_old);
        v_new = $urandom;
        mask  = $urandom;
        issue(CSRXCHG, CSR_SAVE0, v_new, mask, 32'h1c00_0020, '0, r);
        expect_eq("csrxchg old value", r.rdata, v_old);
        read_reg(CSR_SAVE0, got);
        expect_eq("save0 after csrxchg", got, (v_old & ~mask) | (v_new & mask));

        eentry = $urandom & 32'hffff_ffc0;  // entry is 64-byte aligned
        epc    = $urandom & 32'hffff_fffc;
        write_reg(CSR_EENTRY, eentry);
        write_reg(CSR_CRMD, 32'h0000_000b);  // da, plv3, ie off
        read_reg(CSR_CRMD, got);
        expect_eq("crmd read", got, 32'h0000_000b);
        issue(EXCP, CSR_CRMD, '0, '0, epc, ecode_sys, r);
        expect_eq("excp redirect", r.pc, eentry);
        wait_pulse(1'b0);
        read_reg(CSR_ERA, got);
        expect_eq("era after excp", got, epc);
        read_reg(CSR_ESTAT, got);
        expect_eq("estat ecode", 32'(got[21:16]), 32'(ecode_sys));
        read_reg(CSR_PRMD, got);
        expect_eq("prmd keeps plv3", got, 32'h3);
        expect_eq("crmd plv and ie cleared", 32'(crmd[2:0]), 32'd0);

        issue(ERTN, CSR_CRMD, '0, '0, 32'h1c00_0040, '0, r);
        expect_eq("ertn redirect", r.pc, epc);
        wait_pulse(1'b1);
        expect_eq("crmd restored from prmd", 32'(crmd[2:0]), 32'h3);

        write_reg(CSR_ECFG, 32'h0000_0800);  // timer line only
        write_reg(CSR_TCFG, 32'h0000_0041);  // one shot, 64 cycles
        write_reg(CSR_CRMD, 32'h0000_000c);
        taken = 1'b0;
        for (i = 0; i < max_wait && !taken; i++)
        begin
            issue(CSRRD, CSR_SAVE1, '0, '0, epc, '0, r);
            taken = r.flush;
        end
        if (!taken)
            abort_run("timer interrupt was never taken");
        expect_eq("interrupt redirect", r.pc, eentry);
        wait_pulse(1'b0);
        read_reg(CSR_ESTAT, got);
        expect_eq("estat ecode after interrupt", 32'(got[21:16]), 32'd0);
        expect_eq("timer pending in estat", 32'(got[11]), 32'd1);
        write_reg(CSR_TICLR, 32'h1);
        read_reg(CSR_ESTAT, got);
        expect_eq("timer pending cleared", 32'(got[11]), 32'd0);

        // write dropped by a flush at its acceptance edge
        @(posedge clk);
        #2;
        req.valid = 1'b1;
        req.op    = CSRWR;
        req.num   = CSR_SAVE2;
        req.wdata = $urandom | 32'h1;
        flush     = 1'b1;
        @(posedge clk);
        #2;
        req   = '0;
        flush = 1'b0;
        expect_eq("resp cleared by flush", 32'(resp.flush), 32'd0);
        read_reg(CSR_SAVE2, got);
        expect_eq("save2 after flushed write", got, 32'd0);

        @(posedge clk);
        #2;
        stall     = 1'b1;
        held      = resp;
        req.valid = 1'b1;
        req.op    = CSRWR;
        req.num   = CSR_SAVE3;
        req.wdata = $urandom | 32'h1;
        for (i = 0; i < 4; i++)
        begin
            @(posedge clk);
            #2;
            assert (resp === held)
            else
                abort_run($sformatf("FAIL %0t resp changed under stall", $time));
        end
        stall = 1'b0;
        req   = '0;
        read_reg(CSR_SAVE3, got);
        expect_eq("save3 after stalled write", got, 32'd0);

        if (DUT.u_props.fail_count == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            abort_run("a bound timing assertion failed during the run");
    end

endmodule

// File: sim.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_stage_reg.sv
csr_commit.sv
csr_timer.sv
csr_unit.sv
csr_props.sv
tb_clock.sv
csr_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
